//--- include/led_matrix_defs.svh
`ifndef LED_MATRIX_DEFS_SVH
`define LED_MATRIX_DEFS_SVH

// ==============================
// matrix geometry
// ==============================
`define LM_N_COLS        10     // column pairs per frame
`define LM_N_ROWS        14
`define LM_PIX_PER_COL   28     // two columns of 14 rows

// ==============================
// bus and frame memory
// ==============================
`define LM_DW            32
`define LM_AW            16
`define LM_FB_WORDS      2048   // 32-bit words of frame RAM

// ==============================
// scan timing in clocks
// ==============================
`define LM_LOAD_TIME     10
`define LM_LINE_TIME     128
`define LM_SHIFT_PERIOD  6      // advance half then rclk half
`define LM_DEFAULT_FRAME 0

`endif

//--- hdl/led_matrix_pkg.sv
`include "led_matrix_defs.svh"

package led_matrix_pkg;

    // one RGB565 pixel, upper bits red
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // RAM half-word, raw on the memory side, decoded by the scanner
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_word_u;

    typedef enum logic [1:0] {
        FIELD_BLUE  = 2'd0,
        FIELD_GREEN = 2'd1,
        FIELD_RED   = 2'd2
    } field_e;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`LM_DW/8-1:0]   sel;
        logic [`LM_AW-1:0]     adr;
        logic [`LM_DW-1:0]     dat;
    } wb_req_t;

    typedef struct packed {
        logic        valid;
        logic [14:0] addr;     // half-word address
    } fetch_req_t;

    typedef struct packed {
        logic   display_active;
        logic   load_active;
        logic   col_first;
        field_e field;
    } scan_status_t;

endpackage

//--- hdl/wb_frame_port.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module wb_frame_port (
    input  logic                        clk,
    input  logic                        rst,
    input  led_matrix_pkg::wb_req_t     wb_req_i,
    output logic [`LM_DW-1:0]           wb_dat_o,
    output logic                        wb_ack_o,
    input  led_matrix_pkg::fetch_req_t  fetch_req_i,
    output led_matrix_pkg::pixel_word_u fetch_data_o,
    input  logic [14:0]                 base_addr_i,
    output logic [14:0]                 frame_addr_o,
    output logic                        bus_ram_live_o
);
    localparam int IDX_W   = $clog2(`LM_FB_WORDS);
    localparam int N_BYTES = `LM_DW / 8;

    logic [`LM_DW-1:0] mem [`LM_FB_WORDS];
    logic [`LM_DW-1:0] ram_q;
    logic [IDX_W-1:0]  ram_idx;
    logic              live;
    logic              reg_live;
    logic              ram_go;
    logic              ram_we;
    logic              half_sel_q;
    logic              pending;

    assign live           = wb_req_i.cyc && wb_req_i.stb && !wb_ack_o;
    assign reg_live       = live && (wb_req_i.adr == '0);
    assign bus_ram_live_o = live && (wb_req_i.adr != '0);
    assign ram_go         = bus_ram_live_o && !fetch_req_i.valid;  // scanner owns RAM while valid
    assign ram_we         = ram_go && wb_req_i.we;

    // word index, scanner address is in half-words
    assign ram_idx = fetch_req_i.valid ? fetch_req_i.addr[IDX_W:1] : wb_req_i.adr[IDX_W-1:0];

    // ==============================
    // frame RAM
    // ==============================
    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int b = 0; b < N_BYTES; b++) begin
                if (wb_req_i.sel[b]) mem[ram_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
            end
        end
        ram_q      <= mem[ram_idx];
        half_sel_q <= fetch_req_i.addr[0];   // odd pixel in upper half
    end

    assign fetch_data_o.raw = half_sel_q ? ram_q[31:16] : ram_q[15:0];

    // ==============================
    // control register and ack
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_addr_o <= 15'(`LM_DEFAULT_FRAME);
            wb_ack_o     <= 1'b0;
        end else begin
            wb_ack_o <= reg_live || ram_go;
            if (reg_live && wb_req_i.we) frame_addr_o <= wb_req_i.dat[15:1];
        end
    end

    assign pending = (frame_addr_o != base_addr_i);  // scanner not yet on new frame

    always_comb begin
        if (wb_req_i.adr == '0) wb_dat_o = {pending, 15'd0, frame_addr_o, 1'b0};
        else wb_dat_o = ram_q;
    end

    // ==============================
    // checks
    // ==============================
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |=> !wb_ack_o);

    // the whole three-cycle fetch window is free of bus writes
    fetch_no_write: assert property (@(posedge clk) disable iff (rst)
        $rose(fetch_req_i.valid) |-> (fetch_req_i.valid && !ram_we) [*3]);

endmodule

//--- hdl/scan_sequencer.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module scan_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            bus_ram_live_i,
    input  logic [14:0]                     frame_addr_i,
    output led_matrix_pkg::fetch_req_t      fetch_req_o,
    input  led_matrix_pkg::pixel_word_u     fetch_data_i,
    output logic [14:0]                     base_addr_o,
    output logic [`LM_PIX_PER_COL-1:0][5:0] pixels_o,
    output led_matrix_pkg::scan_status_t    status_o,
    output logic                            frame_complete_o
);
    import led_matrix_pkg::*;

    localparam int COL_W = $clog2(`LM_N_COLS);
    localparam int PIX_W = $clog2(`LM_PIX_PER_COL);
    localparam int TMR_W = $clog2(`LM_LINE_TIME + `LM_LOAD_TIME);

    localparam logic [5:0] ST_START  = 6'b000001;  // wait for idle bus
    localparam logic [5:0] ST_FETCH2 = 6'b000010;
    localparam logic [5:0] ST_FETCH3 = 6'b000100;  // data valid here
    localparam logic [5:0] ST_NEXT   = 6'b001000;  // bus slot
    localparam logic [5:0] ST_LOAD   = 6'b010000;
    localparam logic [5:0] ST_DISP   = 6'b100000;

    logic [5:0]       state_q;
    logic [5:0]       state_d;
    logic [COL_W-1:0] col_q;
    logic [PIX_W-1:0] pix_q;
    logic [TMR_W-1:0] timer_q;
    field_e           field_q;
    logic [5:0]       intensity;
    logic             last_pix;
    logic             timer_done;
    logic             col_wrap;

    assign last_pix   = (pix_q == PIX_W'(`LM_PIX_PER_COL - 1));
    assign timer_done = (timer_q == '0);
    assign col_wrap   = (state_q == ST_DISP) && timer_done && (field_q == FIELD_RED)
                        && (col_q == COL_W'(`LM_N_COLS - 1));

    // ==============================
    // fetch port
    // ==============================
    assign fetch_req_o.valid = ((state_q == ST_START) && !bus_ram_live_i)
                               || (state_q == ST_FETCH2) || (state_q == ST_FETCH3);
    assign fetch_req_o.addr  = base_addr_o + 15'(col_q) * 15'(`LM_PIX_PER_COL) + 15'(pix_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_START:  if (!bus_ram_live_i) state_d = ST_FETCH2;
            ST_FETCH2: state_d = ST_FETCH3;
            ST_FETCH3: state_d = ST_NEXT;
            ST_NEXT:   state_d = last_pix ? ST_LOAD : ST_START;
            ST_LOAD:   if (timer_done) state_d = ST_DISP;
            ST_DISP:   if (timer_done) state_d = ST_START;
            default:   state_d = ST_START;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q          <= ST_START;
            pix_q            <= '0;
            col_q            <= '0;
            timer_q          <= '0;
            field_q          <= FIELD_BLUE;
            base_addr_o      <= '0;
            frame_complete_o <= 1'b0;
        end else begin
            state_q          <= state_d;
            frame_complete_o <= col_wrap;
            case (state_q)
                ST_NEXT: begin
                    if (last_pix) begin
                        pix_q   <= '0;
                        timer_q <= TMR_W'(`LM_LOAD_TIME - 1);
                    end else begin
                        pix_q <= pix_q + 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (timer_done) timer_q <= TMR_W'(`LM_LINE_TIME - 1);
                    else timer_q <= timer_q - 1'b1;
                end
                ST_DISP: begin
                    if (!timer_done) begin
                        timer_q <= timer_q - 1'b1;
                    end else if (field_q == FIELD_BLUE) begin
                        field_q <= FIELD_GREEN;
                    end else if (field_q == FIELD_GREEN) begin
                        field_q <= FIELD_RED;
                    end else begin
                        field_q <= FIELD_BLUE;
                        if (col_wrap) begin
                            col_q       <= '0;
                            base_addr_o <= frame_addr_i;  // new frame from here on
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // ==============================
    // pixel latches
    // ==============================
    always_comb begin
        if (base_addr_o == '0) begin
            intensity = '0;   // blank frame
        end else begin
            case (field_q)
                FIELD_GREEN: intensity = fetch_data_i.rgb.g;
                FIELD_RED:   intensity = {fetch_data_i.rgb.r, 1'b0};
                default:     intensity = {fetch_data_i.rgb.b, 1'b0};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FETCH3) pixels_o[pix_q] <= intensity;
    end

    assign status_o.display_active = (state_q == ST_DISP);
    assign status_o.load_active    = (state_q == ST_LOAD);
    assign status_o.col_first      = (col_q == '0) && (field_q == FIELD_BLUE);
    assign status_o.field          = field_q;

    state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state_q));

endmodule

//--- hdl/pwm_row_driver.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module pwm_row_driver (
    input  logic                            clk,
    input  logic                            rst,
    input  led_matrix_pkg::scan_status_t    status_i,
    input  logic [`LM_PIX_PER_COL-1:0][5:0] pixels_i,
    output logic [3:0]                      latch_row_bank_o,
    output logic [7:0]                      row_data_o,
    output logic                            col_first_o,
    output logic                            col_advance_o,
    output logic                            col_rclk_o
);
    localparam int         N_BANKS    = 4;
    localparam int         SHIFT_W    = $clog2(`LM_SHIFT_PERIOD + 1);
    localparam int         HALF_SHIFT = `LM_SHIFT_PERIOD / 2;
    localparam logic [5:0] RAMP_MAX   = 6'd63;

    logic [5:0]                 ramp_q;
    logic [`LM_PIX_PER_COL-1:0] led_q;
    logic [8*N_BANKS-1:0]       led_pad;
    logic                       display_q;
    logic                       load_q;
    logic [2:0]                 bank_cnt_q;
    logic [1:0]                 bank;
    logic [SHIFT_W-1:0]         shift_cnt_q;

    // ==============================
    // PWM engine
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ramp_q    <= '0;
            led_q     <= '0;
            display_q <= 1'b0;
        end else begin
            display_q <= status_i.display_active;
            if (!status_i.display_active) begin
                ramp_q <= '0;
                led_q  <= '0;
            end else begin
                if (ramp_q != RAMP_MAX) ramp_q <= ramp_q + 1'b1;  // holds at top
                for (int i = 0; i < `LM_PIX_PER_COL; i++) begin
                    if (!display_q) led_q[i] <= (pixels_i[i] != '0);
                    else if (pixels_i[i] == ramp_q) led_q[i] <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // row bank mux
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) bank_cnt_q <= '0;
        else bank_cnt_q <= bank_cnt_q + 1'b1;
    end

    assign bank             = bank_cnt_q[2:1];   // two clocks per bank
    assign latch_row_bank_o = 4'b0001 << bank;
    assign led_pad          = (8*N_BANKS)'(led_q);
    assign row_data_o       = led_pad[8*bank +: 8];

    // column shift after each load window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_q      <= 1'b0;
            shift_cnt_q <= '0;
            col_first_o <= 1'b0;
        end else begin
            load_q      <= status_i.load_active;
            col_first_o <= status_i.col_first;
            if (load_q && !status_i.load_active) shift_cnt_q <= SHIFT_W'(`LM_SHIFT_PERIOD);
            else if (shift_cnt_q != '0) shift_cnt_q <= shift_cnt_q - 1'b1;
        end
    end

    assign col_advance_o = (shift_cnt_q > SHIFT_W'(HALF_SHIFT));
    assign col_rclk_o    = (shift_cnt_q != '0) && (shift_cnt_q <= SHIFT_W'(HALF_SHIFT));

    shift_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(col_advance_o && col_rclk_o));

endmodule

//--- hdl/led_matrix.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module led_matrix (
    input  logic                    clk,
    input  logic                    rst,
    input  led_matrix_pkg::wb_req_t wb_req_i,
    output logic [`LM_DW-1:0]       wb_dat_o,
    output logic                    wb_ack_o,
    output logic [3:0]              latch_row_bank_o,
    output logic [7:0]              row_data_o,
    output logic                    col_first_o,
    output logic                    col_advance_o,
    output logic                    col_rclk_o,
    output logic                    frame_complete_o
);
    import led_matrix_pkg::*;

    fetch_req_t                      fetch_req;
    pixel_word_u                     fetch_data;
    scan_status_t                    scan_status;
    logic [14:0]                     frame_addr;
    logic [14:0]                     base_addr;
    logic                            bus_ram_live;
    logic [`LM_PIX_PER_COL-1:0][5:0] pixels;

    wb_frame_port u_wb_frame_port (
        .clk            (clk),
        .rst            (rst),
        .wb_req_i       (wb_req_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .fetch_req_i    (fetch_req),
        .fetch_data_o   (fetch_data),
        .base_addr_i    (base_addr),
        .frame_addr_o   (frame_addr),
        .bus_ram_live_o (bus_ram_live)
    );

    scan_sequencer u_scan_sequencer (
        .clk              (clk),
        .rst              (rst),
        .bus_ram_live_i   (bus_ram_live),
        .frame_addr_i     (frame_addr),
        .fetch_req_o      (fetch_req),
        .fetch_data_i     (fetch_data),
        .base_addr_o      (base_addr),
        .pixels_o         (pixels),
        .status_o         (scan_status),
        .frame_complete_o (frame_complete_o)
    );

    pwm_row_driver u_pwm_row_driver (
        .clk              (clk),
        .rst              (rst),
        .status_i         (scan_status),
        .pixels_i         (pixels),
        .latch_row_bank_o (latch_row_bank_o),
        .row_data_o       (row_data_o),
        .col_first_o      (col_first_o),
        .col_advance_o    (col_advance_o),
        .col_rclk_o       (col_rclk_o)
    );

endmodule

//--- dv/led_checker.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module led_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_ack_i,
    input  logic [31:0] wb_dat_i,
    input  int          op_idx_i,
    input  logic        armed_i,
    input  logic [3:0]  latch_row_bank_i,
    input  logic [7:0]  row_data_i,
    input  logic        col_first_i,
    input  logic        col_advance_i,
    input  logic        col_rclk_i,
    input  logic        frame_complete_i,
    output int          err_count_o,
    output logic        scan_checked_o
);
    localparam int N_WORDS = 320;
    localparam int N_PIX   = `LM_PIX_PER_COL;
    localparam int HALF    = `LM_SHIFT_PERIOD / 2;
    localparam int N_LOADS = 3 * `LM_N_COLS;   // one load window per field

    logic [31:0] pat [N_WORDS];
    int          exp_int [N_PIX];
    int          lit_cnt [N_PIX];
    logic [3:0]  bank_q;
    int          bank_run;
    logic        bank_seen;
    logic        adv_q;
    logic        rclk_q;
    int          adv_run;
    int          rclk_run;
    int          adv_cnt;
    int          first_cnt;
    logic        first_q;
    logic        counting;

    initial begin
        foreach (pat[i]) pat[i] = '0;
        foreach (exp_int[i]) exp_int[i] = 0;
        $readmemh("dv/led_patterns.hex", pat);
        for (int r = 0; r < N_WORDS / 5; r++) begin
            if (pat[5*r] == 4) begin
                for (int j = 0; j < 4; j++) begin
                    exp_int[pat[5*r+1] + j] = int'(pat[5*r+2][8*j +: 8]);
                end
            end
        end
        err_count_o    = 0;
        scan_checked_o = 1'b0;
        bank_q         = 4'b0001;   // bank 0 during reset
        bank_run       = 0;
        bank_seen      = 1'b0;
        adv_q          = 1'b0;
        rclk_q         = 1'b0;
        adv_run        = 0;
        rclk_run       = 0;
        adv_cnt        = 0;
        first_cnt      = 0;
        first_q        = 1'b0;
        counting       = 1'b0;
    end

    task automatic check_bus();
        logic [31:0] exp;
        if (wb_ack_i && pat[5*op_idx_i] == 2) begin
            exp = pat[5*op_idx_i+4];
            if (wb_dat_i !== exp) begin
                $display("ERR wb_dat_o: got %h expected %h", wb_dat_i, exp);
                err_count_o++;
            end
        end
    endtask

    // ==============================
    // row bank rotation
    // ==============================
    task automatic check_banks();
        if (!$onehot(latch_row_bank_i)) begin
            $display("ERR latch_row_bank_o: got %h, not one-hot", latch_row_bank_i);
            err_count_o++;
        end else if (latch_row_bank_i == bank_q) begin
            bank_run++;
        end else begin
            if (bank_seen && bank_run != 2) begin
                $display("row bank %h was held %0d cycles instead of 2", bank_q, bank_run);
                err_count_o++;
            end
            if (latch_row_bank_i != {bank_q[2:0], bank_q[3]}) begin
                $display("ERR latch_row_bank_o: got %h expected %h", latch_row_bank_i,
                         {bank_q[2:0], bank_q[3]});
                err_count_o++;
            end
            bank_seen = 1'b1;
            bank_q    = latch_row_bank_i;
            bank_run  = 1;
        end
        if (latch_row_bank_i[3] && row_data_i[7:4] != 4'h0) begin
            $display("ERR row_data_o: got %h expected upper bits 0 in bank 3", row_data_i);
            err_count_o++;
        end
    endtask

    task automatic check_shift();
        if (col_advance_i && col_rclk_i) begin
            $display("col_advance_o and col_rclk_o are high together");
            err_count_o++;
        end
        if (col_rclk_i && !rclk_q && !adv_q) begin
            $display("col_rclk_o rose without a col_advance_o pulse just before it");
            err_count_o++;
        end
        if (col_advance_i && !adv_q) adv_cnt++;
        if (col_advance_i) begin
            adv_run++;
        end else if (adv_run != 0) begin
            if (adv_run != HALF) begin
                $display("ERR col_advance_o width: got %h expected %h", adv_run, HALF);
                err_count_o++;
            end
            adv_run = 0;
        end
        if (col_rclk_i) begin
            rclk_run++;
        end else if (rclk_run != 0) begin
            if (rclk_run != HALF) begin
                $display("ERR col_rclk_o width: got %h expected %h", rclk_run, HALF);
                err_count_o++;
            end
            rclk_run = 0;
        end
        adv_q  = col_advance_i;
        rclk_q = col_rclk_i;
    endtask

    // ==============================
    // column 0 blue field scan
    // ==============================
    task automatic eval_scan();
        int lo;
        int hi;
        for (int p = 0; p < N_PIX; p++) begin
            lo = (exp_int[p] == 0) ? 0 : exp_int[p] / 4 - 2;   // p cycles lit, 2 of 8 sampled
            hi = (exp_int[p] == 0) ? 0 : exp_int[p] / 4 + 2;
            if (lo < 0) lo = 0;
            if (lit_cnt[p] < lo || lit_cnt[p] > hi) begin
                $display("ERR row_data_o pixel %0d lit samples: got %h expected %h to %h",
                         p, lit_cnt[p], lo, hi);
                err_count_o++;
            end
            for (int q = 0; q < N_PIX; q++) begin
                if (exp_int[q] >= exp_int[p] + 16 && lit_cnt[q] <= lit_cnt[p]) begin
                    $display("pixel %0d is lit less often than dimmer pixel %0d", q, p);
                    err_count_o++;
                end
            end
        end
    endtask

    task automatic check_scan();
        int bank;
        bank = 0;
        if (col_first_i && !first_q && armed_i && !scan_checked_o) begin
            counting = 1'b1;
            foreach (lit_cnt[i]) lit_cnt[i] = 0;
        end
        if (counting && !col_first_i) begin
            counting       = 1'b0;
            scan_checked_o = 1'b1;
            eval_scan();
        end else if (counting) begin
            for (int k = 0; k < 4; k++) begin
                if (latch_row_bank_i[k]) bank = k;
            end
            for (int b = 0; b < 8; b++) begin
                if (8 * bank + b < N_PIX && row_data_i[b]) lit_cnt[8*bank+b]++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if (wb_ack_i || row_data_i != 8'h0 || col_advance_i || col_rclk_i
                || frame_complete_i) begin
                $display("an output is not low during reset");
                err_count_o++;
            end
        end else begin
            check_bus();
            check_banks();
            check_shift();
            check_scan();
            if (col_first_i && !first_q) first_cnt++;
            if (frame_complete_i) begin
                if (first_cnt != 1) begin
                    $display("col_first_o rose %0d times in one frame", first_cnt);
                    err_count_o++;
                end
                if (adv_cnt != N_LOADS) begin
                    $display("col_advance_o pulsed %0d times in one frame instead of %0d",
                             adv_cnt, N_LOADS);
                    err_count_o++;
                end
                first_cnt = 0;
                adv_cnt   = 0;
            end
            first_q = col_first_i;
        end
    end

endmodule

//--- dv/tb_led_matrix.sv
`timescale 1ns/1ps
`include "led_matrix_defs.svh"

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int N_WORDS     = 320;
    localparam int ACK_LIMIT   = 20;
    localparam int RAM_ACK_MAX = 9;
    localparam int FRAME_LIMIT = 10000;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic [3:0]  latch_row_bank;
    logic [7:0]  row_data;
    logic        col_first;
    logic        col_advance;
    logic        col_rclk;
    logic        frame_complete;
    logic [31:0] pat [N_WORDS];
    logic [16:0] lfsr;
    int          op_idx;
    logic        armed;
    int          tb_errors;
    int          chk_errors;
    logic        scan_checked;

    led_matrix u_led_matrix (
        .clk              (clk),
        .rst              (rst),
        .wb_req_i         (wb_req),
        .wb_dat_o         (wb_dat),
        .wb_ack_o         (wb_ack),
        .latch_row_bank_o (latch_row_bank),
        .row_data_o       (row_data),
        .col_first_o      (col_first),
        .col_advance_o    (col_advance),
        .col_rclk_o       (col_rclk),
        .frame_complete_o (frame_complete)
    );

    led_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .wb_ack_i         (wb_ack),
        .wb_dat_i         (wb_dat),
        .op_idx_i         (op_idx),
        .armed_i          (armed),
        .latch_row_bank_i (latch_row_bank),
        .row_data_i       (row_data),
        .col_first_i      (col_first),
        .col_advance_i    (col_advance),
        .col_rclk_i       (col_rclk),
        .frame_complete_i (frame_complete),
        .err_count_o      (chk_errors),
        .scan_checked_o   (scan_checked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 17-bit Fibonacci LFSR, taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic random_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_step(lfsr);
            gap  = 2 * gap + int'(lfsr[0]);
        end
        repeat (gap + 1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < ACK_LIMIT);
        if (!wb_ack) begin
            $display("bus timeout: no ack for address %h within %0d cycles", adr, ACK_LIMIT);
            tb_errors++;
        end else if (adr == '0 && n != 1) begin
            $display("register ack came %0d cycles after the request instead of 1", n);
            tb_errors++;
        end else if (n > RAM_ACK_MAX) begin
            $display("RAM ack came %0d cycles after the request, not under 10", n);
            tb_errors++;
        end
        wb_req.cyc = 1'b0;   // ack seen, drop the request
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!frame_complete && n < FRAME_LIMIT);
        if (!frame_complete) begin
            $display("timeout: no frame_complete_o within %0d cycles", FRAME_LIMIT);
            tb_errors++;
        end
    endtask

    // ==============================
    // pattern sequence
    // ==============================
    initial begin
        int rec;
        rst       = 1'b1;
        wb_req    = '0;
        op_idx    = 0;
        armed     = 1'b0;
        tb_errors = 0;
        lfsr      = 17'd86822;
        foreach (pat[i]) pat[i] = '0;
        $readmemh("dv/led_patterns.hex", pat);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        rec = 0;
        while (rec < N_WORDS / 5 && pat[5*rec] != 0) begin
            op_idx = rec;
            case (pat[5*rec])
                1: bus_access(1'b1, pat[5*rec+1][15:0], pat[5*rec+2], pat[5*rec+3][3:0]);
                2: bus_access(1'b0, pat[5*rec+1][15:0], pat[5*rec+2], pat[5*rec+3][3:0]);
                3: wait_frame();
                5: armed = 1'b1;
                default: ;   // intensity records are for the checker
            endcase
            if (pat[5*rec] == 1 || pat[5*rec] == 2) random_gap();
            rec++;
        end
        if (armed && !scan_checked) begin
            $display("the column 0 scan check never ran");
            tb_errors++;
        end
        $display("checker errors %0d, testbench errors %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hdl/led_matrix_pkg.sv
hdl/wb_frame_port.sv
hdl/scan_sequencer.sv
hdl/pwm_row_driver.sv
hdl/led_matrix.sv
dv/led_checker.sv
dv/tb_led_matrix.sv

//--- Makefile
TOOL     = verilator
TOP      = tb_led_matrix
FILELIST = filelist.f
FLAGS    = --binary --timing --assert -Wno-fatal
LOG      = sim.log
OBJ      = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- dv/led_patterns.hex
// columns: op addr data sel expected; op 1 write, 2 read and compare, 3 wait for frame_complete,
// 4 blue intensities of pixels addr..addr+3 one per byte, 5 arm the column 0 scan check, 0 end
2 0000 00000000 0 00000000  // control after reset
1 0000 00000400 f 00000000  // frame at word 0x100
2 0000 00000000 0 80000400
1 0300 ffffffff f 00000000
1 0300 00000000 5 00000000
2 0300 00000000 0 ff00ff00
1 0300 12345678 a 00000000
2 0300 00000000 0 12005600
1 0100 afe9afe0 f 00000000  // column 0 pixels, red 15 green 3f
1 0101 affbaff2 f 00000000
1 0102 afedafe4 f 00000000
1 0103 afffaff6 f 00000000
1 0104 aff1afe8 f 00000000
1 0105 afe3affa f 00000000
1 0106 aff5afec f 00000000
1 0107 afe7affe f 00000000
1 0108 aff9aff0 f 00000000
1 0109 afebafe2 f 00000000
1 010a affdaff4 f 00000000
1 010b afefafe6 f 00000000
1 010c afe1aff8 f 00000000
1 010d aff3afea f 00000000
2 0107 00000000 0 afe7affe
4 0000 36241200 0 00000000
4 0004 3e2c1a08 0 00000000
4 0008 06342210 0 00000000
4 000c 0e3c2a18 0 00000000
4 0010 16043220 0 00000000
4 0014 1e0c3a28 0 00000000
4 0018 26140230 0 00000000
5 0000 00000000 0 00000000
3 0000 00000000 0 00000000
2 0000 00000000 0 00000400  // pending clear
1 0300 a5a5a5a5 3 00000000
2 0300 00000000 0 1200a5a5
3 0000 00000000 0 00000000
2 0000 00000000 0 00000400
0 0000 00000000 0 00000000
